// File: src/ifu_axi_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 read-side constants for the fetch master
// single-beat reads only, 32-bit data bus
// fetch_q_depth must be a power of two, pointers wrap naturally
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ifu_axi_pkg;

    localparam int axi_id_width   = 2;  // epoch id, wraps after 4 redirects
    localparam int axi_addr_width = 32;
    localparam int axi_data_width = 32;
    localparam int axi_user_width = 4;  // ARUSER tied off, RUSER ignored

    // fixed AR fields
    localparam logic [7:0] ar_len   = 8'd0;  // one beat
    localparam logic [2:0] ar_size  = 3'($clog2(axi_data_width / 8));  // 4 bytes
    localparam logic [1:0] ar_burst = 2'b01;  // INCR
    localparam logic [3:0] ar_cache = 4'b0010;  // normal non-cacheable non-bufferable

    localparam int fetch_q_depth = 4;  // max reads in flight

    // RRESP codes, bit 1 set means error
    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } axi_resp_e;

endpackage

`default_nettype wire

// File: src/ifu_isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32 fetch-side definitions
// no compressed instructions, all fetches are word aligned
// only JAL is acted on, other opcodes are informational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ifu_isa_pkg;

    localparam int inst_width = 32;
    localparam int pc_width   = 32;

    localparam logic [pc_width-1:0] reset_pc = 32'h0000_0000;  // first fetch address

    // major opcode sits in inst[6:0]
    localparam int opcode_width = 7;

    typedef enum logic [opcode_width-1:0] {
        op_op_imm = 7'b0010011,  // addi and friends
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,  // not predicted here
        op_jal    = 7'b1101111   // unconditional, redirects fetch
    } opcode_e;

    // JAL offset, bit 0 always zero
    // imm[20]    = inst[31]
    // imm[10:1]  = inst[30:21]
    // imm[11]    = inst[20]
    // imm[19:12] = inst[19:12]
    localparam int jal_imm_width = 21;

endpackage

`default_nettype wire

// File: src/fetch_pc_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch program counter
// steps by 4 per accepted AR, jump load wins over any stall
// jump targets are assumed word aligned
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             pc_stall_i,     // AR not taken or queue full
    input  logic                             stall_i,        // downstream hold
    input  logic                             jump_i,         // one-cycle redirect pulse
    input  logic [ifu_isa_pkg::pc_width-1:0] jump_target_i,
    output logic [ifu_isa_pkg::pc_width-1:0] pc_o
);

    logic [ifu_isa_pkg::pc_width-1:0] pc_q;
    logic                             advance;

    // neither hold active means the AR at pc_q was accepted this cycle
    assign advance = !pc_stall_i && !stall_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= ifu_isa_pkg::reset_pc;
        end else if (jump_i) begin
            pc_q <= jump_target_i;  // redirect, old path dropped by epoch
        end else if (advance) begin
            pc_q <= pc_q + 32'd4;  // next sequential word
        end
    end

    assign pc_o = pc_q;  // drives ARADDR directly

    // target comes from predecode, checks the whole redirect path
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc_o[1:0] == 2'b00
    ) else $error("fetch pc %08h not word aligned", pc_o);

endmodule

`default_nettype wire

// File: src/ifu_axi_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 read master for instruction fetch
// single-beat, in-order slave assumed, ARVALID drops under stall
// ARID carries a redirect epoch; a stale beat from 4 redirects
// back would alias, the slave must not hold one that long
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ifu_axi_master (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   stall_i,
    input  logic                                   jump_i,
    input  logic [ifu_isa_pkg::pc_width-1:0]       pc_i,
    output logic                                   resp_valid_o,
    output logic [ifu_isa_pkg::inst_width-1:0]     resp_data_o,
    output logic [ifu_isa_pkg::pc_width-1:0]       resp_addr_o,
    output logic                                   pc_stall_o,
    output logic                                   read_resp_error_o,
    // read address channel
    output logic [ifu_axi_pkg::axi_id_width-1:0]   m_axi_arid_o,
    output logic [ifu_axi_pkg::axi_addr_width-1:0] m_axi_araddr_o,
    output logic [7:0]                             m_axi_arlen_o,
    output logic [2:0]                             m_axi_arsize_o,
    output logic [1:0]                             m_axi_arburst_o,
    output logic                                   m_axi_arlock_o,
    output logic [3:0]                             m_axi_arcache_o,
    output logic [2:0]                             m_axi_arprot_o,
    output logic [3:0]                             m_axi_arqos_o,
    output logic [ifu_axi_pkg::axi_user_width-1:0] m_axi_aruser_o,
    output logic                                   m_axi_arvalid_o,
    input  logic                                   m_axi_arready_i,
    // read data channel
    input  logic [ifu_axi_pkg::axi_id_width-1:0]   m_axi_rid_i,
    input  logic [ifu_axi_pkg::axi_data_width-1:0] m_axi_rdata_i,
    input  logic [1:0]                             m_axi_rresp_i,
    input  logic                                   m_axi_rlast_i,
    input  logic [ifu_axi_pkg::axi_user_width-1:0] m_axi_ruser_i,
    input  logic                                   m_axi_rvalid_i,
    output logic                                   m_axi_rready_o
);

    localparam int q_ptr_w = $clog2(ifu_axi_pkg::fetch_q_depth);
    localparam int q_cnt_w = q_ptr_w + 1;  // holds 0..depth

    logic [ifu_axi_pkg::axi_id_width-1:0] epoch_q;  // current ARID
    logic                                 error_q;  // sticky
    logic [ifu_isa_pkg::pc_width-1:0]     addr_q [ifu_axi_pkg::fetch_q_depth];
    logic [q_ptr_w-1:0]                   rd_ptr_q;
    logic [q_ptr_w-1:0]                   wr_ptr_q;
    logic [q_cnt_w-1:0]                   count_q;

    logic                   q_empty;
    logic                   q_full;
    logic                   ar_hsk;
    logic                   r_hsk;
    logic                   id_hsk;  // beat of the current epoch
    logic                   resp_err;
    logic                   same_cycle;
    logic                   push;
    logic                   pop;
    ifu_axi_pkg::axi_resp_e rresp;

    assign q_empty = (count_q == '0);
    assign q_full  = (count_q == q_cnt_w'(ifu_axi_pkg::fetch_q_depth));

    assign ar_hsk = m_axi_arvalid_o && m_axi_arready_i;
    assign r_hsk  = m_axi_rvalid_i && m_axi_rready_o;
    assign id_hsk = r_hsk && (m_axi_rid_i == epoch_q);  // stale ids fall out here

    assign rresp    = ifu_axi_pkg::axi_resp_e'(m_axi_rresp_i);
    assign resp_err = (rresp == ifu_axi_pkg::slverr) || (rresp == ifu_axi_pkg::decerr);

    // empty queue, addr taken and answered in one cycle, bypass the queue
    assign same_cycle = ar_hsk && id_hsk && q_empty;
    assign push       = ar_hsk && !same_cycle;
    assign pop        = id_hsk && !q_empty;  // error beats pop too, keeps order

    // AR channel, fixed single-beat word reads
    assign m_axi_arid_o    = epoch_q;
    assign m_axi_araddr_o  = pc_i;
    assign m_axi_arlen_o   = ifu_axi_pkg::ar_len;
    assign m_axi_arsize_o  = ifu_axi_pkg::ar_size;
    assign m_axi_arburst_o = ifu_axi_pkg::ar_burst;
    assign m_axi_arlock_o  = 1'b0;
    assign m_axi_arcache_o = ifu_axi_pkg::ar_cache;
    assign m_axi_arprot_o  = 3'b100;  // instruction, secure, unprivileged
    assign m_axi_arqos_o   = 4'h0;
    assign m_axi_aruser_o  = '0;
    assign m_axi_arvalid_o = !stall_i && !q_full;
    assign m_axi_rready_o  = !stall_i;

    assign pc_stall_o = (m_axi_arvalid_o && !m_axi_arready_i) || q_full;

    // response side, data straight from the bus
    assign resp_valid_o      = id_hsk && !resp_err;
    assign resp_data_o       = m_axi_rdata_i;
    assign resp_addr_o       = same_cycle ? pc_i : addr_q[rd_ptr_q];
    assign read_resp_error_o = error_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            epoch_q  <= '0;
            error_q  <= 1'b0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (id_hsk && resp_err) begin
                error_q <= 1'b1;  // stays until reset
            end
            if (jump_i) begin
                epoch_q  <= epoch_q + 1'b1;  // in-flight reads become stale
                rd_ptr_q <= '0;
                wr_ptr_q <= '0;
                count_q  <= '0;
            end else begin
                if (push) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
                if (pop) begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
                case ({push, pop})
                    2'b10:   count_q <= count_q + 1'b1;
                    2'b01:   count_q <= count_q - 1'b1;
                    default: count_q <= count_q;  // none, or push and pop together
                endcase
            end
        end
    end

    // issued addresses, oldest at rd_ptr_q
    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr_q] <= pc_i;
        end
    end

    a_q_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count_q <= q_cnt_w'(ifu_axi_pkg::fetch_q_depth)
    ) else $error("fetch queue count %0d over depth", count_q);

    // a current-epoch beat needs a queued address or the one issued now
    a_resp_has_addr: assert property (
        @(posedge clk) disable iff (!rst_n)
        id_hsk && q_empty |-> ar_hsk
    ) else $error("response id %0d with no outstanding read", m_axi_rid_i);

    // slave keeps to single beats with defined sideband
    a_single_beat: assert property (
        @(posedge clk) disable iff (!rst_n)
        r_hsk |-> m_axi_rlast_i && !$isunknown(m_axi_ruser_i)
    ) else $error("R beat without RLAST or with unknown RUSER");

endmodule

`default_nettype wire

// File: src/inst_predecode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// predecode and output register
// spots JAL only, redirect pulse is combinational from the beat
// register holds while stall_i is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module inst_predecode (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               stall_i,
    input  logic                               resp_valid_i,  // good beat, current epoch
    input  logic [ifu_isa_pkg::inst_width-1:0] resp_data_i,
    input  logic [ifu_isa_pkg::pc_width-1:0]   resp_addr_i,
    output logic                               jump_o,
    output logic [ifu_isa_pkg::pc_width-1:0]   jump_target_o,
    output logic                               inst_valid_o,
    output logic [ifu_isa_pkg::inst_width-1:0] inst_o,
    output logic [ifu_isa_pkg::pc_width-1:0]   inst_pc_o
);

    localparam int sext_w = ifu_isa_pkg::pc_width - ifu_isa_pkg::jal_imm_width;

    ifu_isa_pkg::opcode_e                    opcode;
    logic [ifu_isa_pkg::jal_imm_width-1:0]   jal_imm;
    logic [ifu_isa_pkg::pc_width-1:0]        jal_offset;
    logic                                    valid_q;
    logic [ifu_isa_pkg::inst_width-1:0]      inst_q;
    logic [ifu_isa_pkg::pc_width-1:0]        pc_q;

    // major opcode from the low bits
    assign opcode = ifu_isa_pkg::opcode_e'(resp_data_i[ifu_isa_pkg::opcode_width-1:0]);

    // J-type immediate, bits scattered over the word
    assign jal_imm = {
        resp_data_i[31],     // imm[20]
        resp_data_i[19:12],  // imm[19:12]
        resp_data_i[20],     // imm[11]
        resp_data_i[30:21],  // imm[10:1]
        1'b0
    };

    // sign extend to pc width
    assign jal_offset = {{sext_w{jal_imm[ifu_isa_pkg::jal_imm_width-1]}}, jal_imm};

    // redirect in the accept cycle, pc and epoch move on this edge
    assign jump_o        = resp_valid_i && (opcode == ifu_isa_pkg::op_jal);
    assign jump_target_o = resp_addr_i + jal_offset;  // pc-relative

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= resp_valid_i;  // one-cycle pulse per beat
        end
    end

    // payload, only loads on a taken beat
    always_ff @(posedge clk) begin
        if (resp_valid_i && !stall_i) begin
            inst_q <= resp_data_i;
            pc_q   <= resp_addr_i;
        end
    end

    assign inst_valid_o = valid_q;
    assign inst_o       = inst_q;
    assign inst_pc_o    = pc_q;

    // epoch flip must kill the beat right after a jump
    a_jump_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        jump_o |=> !jump_o
    ) else $error("jump pulse two cycles in a row at %08h", resp_addr_i);

endmodule

`default_nettype wire

// File: src/ifu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch front end top
// AXI4 read master port plus a valid/stall instruction port
// fetch_error_o is sticky until reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   stall_i,
    // read address channel
    output logic [ifu_axi_pkg::axi_id_width-1:0]   m_axi_arid_o,
    output logic [ifu_axi_pkg::axi_addr_width-1:0] m_axi_araddr_o,
    output logic [7:0]                             m_axi_arlen_o,
    output logic [2:0]                             m_axi_arsize_o,
    output logic [1:0]                             m_axi_arburst_o,
    output logic                                   m_axi_arlock_o,
    output logic [3:0]                             m_axi_arcache_o,
    output logic [2:0]                             m_axi_arprot_o,
    output logic [3:0]                             m_axi_arqos_o,
    output logic [ifu_axi_pkg::axi_user_width-1:0] m_axi_aruser_o,
    output logic                                   m_axi_arvalid_o,
    input  logic                                   m_axi_arready_i,
    // read data channel
    input  logic [ifu_axi_pkg::axi_id_width-1:0]   m_axi_rid_i,
    input  logic [ifu_axi_pkg::axi_data_width-1:0] m_axi_rdata_i,
    input  logic [1:0]                             m_axi_rresp_i,
    input  logic                                   m_axi_rlast_i,
    input  logic [ifu_axi_pkg::axi_user_width-1:0] m_axi_ruser_i,
    input  logic                                   m_axi_rvalid_i,
    output logic                                   m_axi_rready_o,
    // downstream
    output logic                                   inst_valid_o,
    output logic [ifu_isa_pkg::inst_width-1:0]     inst_o,
    output logic [ifu_isa_pkg::pc_width-1:0]       inst_pc_o,
    output logic                                   fetch_error_o
);

    logic [ifu_isa_pkg::pc_width-1:0]   pc;
    logic                               pc_stall;
    logic                               jump;  // redirect pulse
    logic [ifu_isa_pkg::pc_width-1:0]   jump_target;
    logic                               resp_valid;
    logic [ifu_isa_pkg::inst_width-1:0] resp_data;
    logic [ifu_isa_pkg::pc_width-1:0]   resp_addr;

    fetch_pc_gen u_pc_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_stall_i   (pc_stall),
        .stall_i      (stall_i),
        .jump_i       (jump),
        .jump_target_i(jump_target),
        .pc_o         (pc)
    );

    ifu_axi_master u_axi_master (
        .clk(clk), .rst_n(rst_n), .stall_i(stall_i), .jump_i(jump), .pc_i(pc),
        .resp_valid_o(resp_valid), .resp_data_o(resp_data), .resp_addr_o(resp_addr),
        .pc_stall_o(pc_stall), .read_resp_error_o(fetch_error_o),
        .m_axi_arid_o(m_axi_arid_o), .m_axi_araddr_o(m_axi_araddr_o),
        .m_axi_arlen_o(m_axi_arlen_o), .m_axi_arsize_o(m_axi_arsize_o),
        .m_axi_arburst_o(m_axi_arburst_o), .m_axi_arlock_o(m_axi_arlock_o),
        .m_axi_arcache_o(m_axi_arcache_o), .m_axi_arprot_o(m_axi_arprot_o),
        .m_axi_arqos_o(m_axi_arqos_o), .m_axi_aruser_o(m_axi_aruser_o),
        .m_axi_arvalid_o(m_axi_arvalid_o), .m_axi_arready_i(m_axi_arready_i),
        .m_axi_rid_i(m_axi_rid_i), .m_axi_rdata_i(m_axi_rdata_i),
        .m_axi_rresp_i(m_axi_rresp_i), .m_axi_rlast_i(m_axi_rlast_i),
        .m_axi_ruser_i(m_axi_ruser_i), .m_axi_rvalid_i(m_axi_rvalid_i),
        .m_axi_rready_o(m_axi_rready_o)
    );

    inst_predecode u_predecode (
        .clk(clk), .rst_n(rst_n), .stall_i(stall_i),
        .resp_valid_i(resp_valid), .resp_data_i(resp_data), .resp_addr_i(resp_addr),
        .jump_o(jump), .jump_target_o(jump_target),
        .inst_valid_o(inst_valid_o), .inst_o(inst_o), .inst_pc_o(inst_pc_o)
    );

endmodule

`default_nettype wire

// File: testbench/tb_axi_mem_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in-order single-beat AXI read slave
// image is a function of address, two JALs and one error word
// outputs change on the falling edge only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem_model (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [ifu_axi_pkg::axi_id_width-1:0]   arid_i,
    input  logic [ifu_axi_pkg::axi_addr_width-1:0] araddr_i,
    input  logic                                   arvalid_i,
    output logic                                   arready_o,
    output logic [ifu_axi_pkg::axi_id_width-1:0]   rid_o,
    output logic [ifu_axi_pkg::axi_data_width-1:0] rdata_o,
    output logic [1:0]                             rresp_o,
    output logic                                   rlast_o,
    output logic [ifu_axi_pkg::axi_user_width-1:0] ruser_o,
    output logic                                   rvalid_o,
    input  logic                                   rready_i
);

    localparam logic [31:0] seed = 32'd50176;

    logic [31:0] jal_a_pc = 32'h40;  // image variant, rewritten between phases
    logic [31:0] jal_a_off = 32'h100;
    logic [31:0] jal_b_pc = 32'h1A0;
    logic [31:0] jal_b_off = -32'sh180;
    logic [31:0] err_pc = 32'h2F0;

    logic [ifu_axi_pkg::axi_addr_width-1:0] addr_fifo [$];  // accepted ARs, oldest first
    logic [ifu_axi_pkg::axi_id_width-1:0]   id_fifo [$];
    logic [31:0] rnd = seed;
    int          head_wait = -1;  // -1 means no latency drawn yet
    int          beats_taken = 0;
    int          beats_seen = 0;

    function automatic logic [31:0] rand_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // J-type encoding, rd = x0
    function automatic logic [31:0] jal_word(input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, ifu_isa_pkg::op_jal};
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (addr == jal_a_pc) return jal_word(jal_a_off);
        if (addr == jal_b_pc) return jal_word(jal_b_off);
        // op-imm filler, upper bits carry the whole word address
        return {25'(addr >> 2) ^ 25'(addr >> 27), ifu_isa_pkg::op_op_imm};
    endfunction

    task automatic load_image(input logic [31:0] a_pc, input logic [31:0] a_off,
                              input logic [31:0] b_pc, input logic [31:0] b_off,
                              input logic [31:0] e_pc);
        jal_a_pc  = a_pc;
        jal_a_off = a_off;
        jal_b_pc  = b_pc;
        jal_b_off = b_off;
        err_pc    = e_pc;
    endtask

    // idle bus until the first falling edge
    initial begin
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        rid_o     = '0;
        rdata_o   = '0;
        rresp_o   = 2'b00;
        rlast_o   = 1'b1;
        ruser_o   = '0;
    end

    // handshakes seen at the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            addr_fifo.delete();
            id_fifo.delete();
            beats_taken = 0;
        end else begin
            if (rvalid_o && rready_i) begin
                void'(addr_fifo.pop_front());
                void'(id_fifo.pop_front());
                beats_taken++;  // tells the drive side to drop RVALID
            end
            if (arvalid_i && arready_o) begin
                addr_fifo.push_back(araddr_i);
                id_fifo.push_back(arid_i);
            end
        end
    end

    always @(negedge clk) begin
        rlast_o = 1'b1;  // single beat
        ruser_o = '0;
        if (!rst_n) begin
            arready_o  = 1'b0;
            rvalid_o   = 1'b0;
            rid_o      = '0;
            rdata_o    = '0;
            rresp_o    = 2'b00;
            head_wait  = -1;
            beats_seen = 0;
        end else begin
            rnd       = rand_step(rnd);
            arready_o = (rnd[17:16] != 2'b00);  // ready about 3 cycles in 4
            if (beats_taken != beats_seen) begin
                rvalid_o   = 1'b0;
                beats_seen = beats_taken;
            end
            if (!rvalid_o && addr_fifo.size() != 0) begin
                if (head_wait < 0) begin
                    rnd       = rand_step(rnd);
                    head_wait = int'((rnd >> 16) % 32'd6);  // 0 to 5 extra cycles
                end
                if (head_wait == 0) begin
                    rid_o     = id_fifo[0];  // echo ARID, stale or not
                    rdata_o   = word_at(addr_fifo[0]);
                    rresp_o   = (addr_fifo[0] == err_pc) ? ifu_axi_pkg::slverr
                                                         : ifu_axi_pkg::okay;
                    rvalid_o  = 1'b1;
                    head_wait = -1;
                end else begin
                    head_wait--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_ifu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch front end testbench, two phases
// phase 1 loops over both JALs, phase 2 lands a JAL on a slverr word
// random stall bursts and slave latencies, fixed seed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_ifu_top;

    localparam logic [31:0] rand_seed = 32'd50176;
    localparam int phase_insts    = 48;  // enough to pass the JAL at 0x1A0
    localparam int timeout_cycles = phase_insts * 8 * 2 + 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        stall_i = 1'b0;
    logic        stall_en = 1'b0;
    logic [31:0] rnd = rand_seed;
    int          burst_left = 0;
    int          errors = 0;
    int          cycles = 0;
    int          outputs = 0;  // per phase
    int          total_out = 0;
    logic [31:0] exp_pc;
    logic [31:0] exp_word;
    logic [31:0] jal_a_pc, jal_a_off, jal_b_pc, jal_b_off, err_pc;

    logic [ifu_axi_pkg::axi_id_width-1:0]   arid, rid;
    logic [ifu_axi_pkg::axi_addr_width-1:0] araddr;
    logic [ifu_axi_pkg::axi_data_width-1:0] rdata;
    logic [ifu_axi_pkg::axi_user_width-1:0] ruser, aruser;
    logic [7:0]  arlen;
    logic [2:0]  arsize, arprot;
    logic [3:0]  arcache, arqos;
    logic [1:0]  arburst, rresp;
    logic        arlock;
    logic        arvalid, arready, rvalid, rready, rlast;
    logic        inst_valid, fetch_error;
    logic [31:0] inst, inst_pc;
    logic        ar_hs, r_hs;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    always #10 clk = ~clk;

    ifu_top dut (
        .clk(clk), .rst_n(rst_n), .stall_i(stall_i),
        .m_axi_arid_o(arid), .m_axi_araddr_o(araddr), .m_axi_arlen_o(arlen),
        .m_axi_arsize_o(arsize), .m_axi_arburst_o(arburst), .m_axi_arlock_o(arlock),
        .m_axi_arcache_o(arcache), .m_axi_arprot_o(arprot), .m_axi_arqos_o(arqos),
        .m_axi_aruser_o(aruser),
        .m_axi_arvalid_o(arvalid), .m_axi_arready_i(arready),
        .m_axi_rid_i(rid), .m_axi_rdata_i(rdata), .m_axi_rresp_i(rresp),
        .m_axi_rlast_i(rlast), .m_axi_ruser_i(ruser), .m_axi_rvalid_i(rvalid),
        .m_axi_rready_o(rready),
        .inst_valid_o(inst_valid), .inst_o(inst), .inst_pc_o(inst_pc),
        .fetch_error_o(fetch_error)
    );

    tb_axi_mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .arid_i(arid), .araddr_i(araddr), .arvalid_i(arvalid),
        .arready_o(arready), .rid_o(rid), .rdata_o(rdata), .rresp_o(rresp),
        .rlast_o(rlast), .ruser_o(ruser), .rvalid_o(rvalid), .rready_i(rready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // program order as the image defines it
    function automatic logic [31:0] next_fetch_pc(input logic [31:0] pc);
        logic [31:0] nxt;
        if (pc == jal_a_pc) nxt = pc + jal_a_off;
        else if (pc == jal_b_pc) nxt = pc + jal_b_off;
        else nxt = pc + 32'd4;
        if (nxt == err_pc) nxt = nxt + 32'd4;  // error beat dropped, fetch runs on
        return nxt;
    endfunction

    task automatic configure_image(input logic [31:0] a_pc, input logic [31:0] a_off,
                                   input logic [31:0] b_pc, input logic [31:0] b_off,
                                   input logic [31:0] e_pc);
        jal_a_pc  = a_pc;
        jal_a_off = a_off;
        jal_b_pc  = b_pc;
        jal_b_off = b_off;
        err_pc    = e_pc;
        u_mem.load_image(a_pc, a_off, b_pc, b_off, e_pc);
    endtask

    task automatic apply_reset();
        stall_en = 1'b0;
        rst_n    = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);  // first cycle after reset runs unstalled
        stall_en = 1'b1;
    endtask

    // stall bursts: high 1..4, low 2..9 cycles
    always @(negedge clk) begin
        if (!stall_en) begin
            stall_i    = 1'b0;
            burst_left = 0;
        end else if (burst_left == 0) begin
            rnd        = lcg_next(rnd);
            stall_i    = !stall_i;
            burst_left = stall_i ? int'((rnd >> 16) % 32'd4) : int'((rnd >> 16) % 32'd8) + 1;
        end else begin
            burst_left--;
        end
    end

    // reference tracker, one step per consumed output
    always @(posedge clk) begin : track
        logic [31:0] nxt;
        if (!rst_n) begin
            exp_pc   <= ifu_isa_pkg::reset_pc;
            exp_word <= u_mem.word_at(ifu_isa_pkg::reset_pc);
            outputs  <= 0;
        end else if (inst_valid && !stall_i) begin
            nxt = next_fetch_pc(exp_pc);
            exp_pc    <= nxt;
            exp_word  <= u_mem.word_at(nxt);
            outputs   <= outputs + 1;
            total_out <= total_out + 1;
        end
    end

    a_seq_pc: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid && !stall_i |-> inst_pc == exp_pc)
    else begin
        errors++;
        $display("** Error: inst_pc_o = %h, expected %h", $sampled(inst_pc), $sampled(exp_pc));
    end

    a_seq_word: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid && !stall_i |-> inst == exp_word)
    else begin
        errors++;
        $display("** Error: inst_o = %h, expected %h", $sampled(inst), $sampled(exp_word));
    end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> $stable(inst_valid) && (!inst_valid || ($stable(inst) && $stable(inst_pc))))
    else begin
        errors++;
        $display("downstream outputs changed while stall_i was high");
    end

    a_no_hsk: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |-> !ar_hs && !r_hs)
    else begin
        errors++;
        $display("AXI handshake happened while stall_i was high");
    end

    a_ar_fields: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> arlen == 8'd0 && arsize == 3'd2 && arburst == 2'b01)
    else begin
        errors++;
        $display("** Error: arlen/arsize/arburst = %h/%h/%h, expected 00/2/1",
                 $sampled(arlen), $sampled(arsize), $sampled(arburst));
    end

    // normal access, normal non-cacheable, instruction fetch, no QoS or user bits
    a_ar_attrs: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> !arlock && arcache == 4'b0010 && arprot[2] && arqos == 4'h0
                    && aruser == '0)
    else begin
        errors++;
        $display("** Error: arlock/arcache/arprot[2]/arqos/aruser = %h/%h/%h/%h/%h, %s",
                 $sampled(arlock), $sampled(arcache), $sampled(arprot[2]),
                 $sampled(arqos), $sampled(aruser), "expected 0/2/1/0/0");
    end

    a_err_set: assert property (@(posedge clk) disable iff (!rst_n)
        r_hs && rid == arid && rresp == ifu_axi_pkg::slverr |=> fetch_error)
    else begin
        errors++;
        $display("fetch_error_o did not rise after a slverr response");
    end

    a_err_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_error |=> fetch_error)
    else begin
        errors++;
        $display("fetch_error_o dropped before reset");
    end

    a_err_hidden: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> inst_pc != err_pc)
    else begin
        errors++;
        $display("** Error: inst_pc_o = %h, the error word was forwarded", $sampled(inst_pc));
    end

    a_reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> !inst_valid && !fetch_error && arid == '0 && (stall_i || arvalid))
    else begin
        errors++;
        $display("** Error: after reset inst_valid_o/fetch_error_o/m_axi_arid_o = %h/%h/%h",
                 $sampled(inst_valid), $sampled(fetch_error), $sampled(arid));
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, %0d of %0d outputs in this phase",
                     cycles, outputs, phase_insts);
            $display("summary: %0d errors, %0d outputs checked", errors + 1, total_out);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        configure_image(32'h40, 32'h100, 32'h1A0, -32'sh180, 32'h2F0);
        apply_reset();
        while (outputs < phase_insts) @(negedge clk);
        assert (!fetch_error) else begin
            errors++;
            $display("** Error: fetch_error_o = %h, expected 0", fetch_error);
        end

        // second variant, the 0x1A0 jump lands on a slverr word
        configure_image(32'h40, 32'h100, 32'h1A0, -32'sh120, 32'h80);
        apply_reset();
        while (outputs < phase_insts) @(negedge clk);
        assert (fetch_error) else begin
            errors++;
            $display("** Error: fetch_error_o = %h, expected 1", fetch_error);
        end

        $display("summary: %0d errors, %0d outputs checked", errors, total_out);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ifu_top.f
src/ifu_axi_pkg.sv
src/ifu_isa_pkg.sv
src/fetch_pc_gen.sv
src/ifu_axi_master.sv
src/inst_predecode.sv
src/ifu_top.sv
testbench/tb_axi_mem_model.sv
testbench/tb_ifu_top.sv

// File: Bender.yml
package:
  name: ifu_top

sources:
  - src/ifu_axi_pkg.sv
  - src/ifu_isa_pkg.sv
  - src/fetch_pc_gen.sv
  - src/ifu_axi_master.sv
  - src/inst_predecode.sv
  - src/ifu_top.sv
  - target: test
    files:
      - testbench/tb_axi_mem_model.sv
      - testbench/tb_ifu_top.sv
